/* design/sound_pkg.sv */
package sound_pkg;

  // Z80 bus
  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  // Mixer and output widths
  localparam int MIX_W = 12;
  localparam int OUT_W = 16;

  // fclk cycles per output sample
  localparam int SAMPLE_DIV = 64;

  // Weights in the 12-bit sum
  localparam int COVOX_W = 4;
  localparam int BEEP_W  = 256;

  // Soundrive channel ports, low address byte
  localparam logic [7:0] PORT_SD_A = 8'h0F;
  localparam logic [7:0] PORT_SD_B = 8'h1F;
  localparam logic [7:0] PORT_SD_C = 8'h4F;
  localparam logic [7:0] PORT_SD_D = 8'h5F;

  // Covox port loads all four channels at once
  localparam logic [7:0] PORT_COVOX = 8'hFB;

  // Beeper bit in a port #FE write
  localparam int BEEP_BIT = 4;

  typedef logic [DATA_W-1:0] level_t;

  // Bit 0 is channel A, bit 3 is channel D
  typedef logic [3:0] chan_mask_t;

  typedef logic [MIX_W-1:0] mix_t;
  typedef logic [OUT_W-1:0] sample_t;

endpackage

/* design/snd_port_decode.sv */
`timescale 1ns/1ps

module snd_port_decode (
  input  logic                        fclk,
  input  logic                        reset,
  input  logic [sound_pkg::ADDR_W-1:0] a,
  input  sound_pkg::level_t           d,
  input  logic                        iorq_n,
  input  logic                        wr_n,
  input  logic                        m1_n,
  input  logic                        dos,
  output sound_pkg::chan_mask_t       chan_wr,
  output logic                        beep_wr,
  output sound_pkg::level_t           wr_data
);

  import sound_pkg::*;

  logic       io_wr;
  logic       io_wr_q;
  logic       io_wr_qq;
  logic       wr_start;
  logic [7:0] addr_q;
  level_t     data_q;
  logic       dos_q;
  chan_mask_t chan_sel;
  logic       covox_hit;

  // I/O write cycle, excluding interrupt acknowledge
  assign io_wr = ~iorq_n & ~wr_n & m1_n;

  // First edge: capture strobes, address and data
  always_ff @(posedge fclk) begin
    if (reset) begin
      io_wr_q  <= 1'b0;
      io_wr_qq <= 1'b0;
    end else begin
      io_wr_q  <= io_wr;
      io_wr_qq <= io_wr_q;
    end
  end

  always_ff @(posedge fclk) begin
    addr_q <= a[7:0];
    data_q <= d;
    dos_q  <= dos;
  end

  assign wr_start = io_wr_q & ~io_wr_qq;

  // Soundrive decode, blocked while DOS is active
  assign covox_hit = (addr_q == PORT_COVOX);

  always_comb begin
    chan_sel    = '0;
    chan_sel[0] = (addr_q == PORT_SD_A) | covox_hit;
    chan_sel[1] = (addr_q == PORT_SD_B) | covox_hit;
    chan_sel[2] = (addr_q == PORT_SD_C) | covox_hit;
    chan_sel[3] = (addr_q == PORT_SD_D) | covox_hit;
    if (dos_q) begin
      chan_sel = '0;
    end
  end

  // Second edge: one-cycle pulses on the start of the write
  always_ff @(posedge fclk) begin
    if (reset) begin
      chan_wr <= '0;
      beep_wr <= 1'b0;
    end else begin
      chan_wr <= wr_start ? chan_sel : '0;
      // Any even port reaches #FE
      beep_wr <= wr_start & ~addr_q[0];
    end
  end

  always_ff @(posedge fclk) begin
    if (wr_start) begin
      wr_data <= data_q;
    end
  end

  // One pulse per bus write, even for long-held cycles
  a_single_pulse: assert property (
    @(posedge fclk) disable iff (reset)
    (beep_wr || (|chan_wr)) |=> !(beep_wr || (|chan_wr))
  );

endmodule

/* design/level_regs.sv */
`timescale 1ns/1ps

module level_regs (
  input  logic                  fclk,
  input  logic                  reset,
  input  sound_pkg::chan_mask_t chan_wr,
  input  logic                  beep_wr,
  input  sound_pkg::level_t     wr_data,
  output sound_pkg::level_t     lvl_a,
  output sound_pkg::level_t     lvl_b,
  output sound_pkg::level_t     lvl_c,
  output sound_pkg::level_t     lvl_d,
  output logic                  beep
);

  import sound_pkg::*;

  // Soundrive channels and the port #FE beeper bit
  always_ff @(posedge fclk) begin
    if (reset) begin
      lvl_a <= '0;
      lvl_b <= '0;
      lvl_c <= '0;
      lvl_d <= '0;
      beep  <= 1'b0;
    end else begin
      if (chan_wr[0]) begin
        lvl_a <= wr_data;
      end
      if (chan_wr[1]) begin
        lvl_b <= wr_data;
      end
      if (chan_wr[2]) begin
        lvl_c <= wr_data;
      end
      if (chan_wr[3]) begin
        lvl_d <= wr_data;
      end
      if (beep_wr) begin
        beep <= wr_data[BEEP_BIT];
      end
    end
  end

  // Levels only move on the edge that samples a decoded write
  a_hold_levels: assert property (
    @(posedge fclk) disable iff (reset)
    (!$past(reset) && !$past(beep_wr) && ($past(chan_wr) == '0))
      |-> $stable({lvl_a, lvl_b, lvl_c, lvl_d, beep})
  );

endmodule

/* design/audio_mixer.sv */
`timescale 1ns/1ps

module audio_mixer (
  input  logic               fclk,
  input  logic               reset,
  input  sound_pkg::level_t  lvl_a,
  input  sound_pkg::level_t  lvl_b,
  input  sound_pkg::level_t  lvl_c,
  input  sound_pkg::level_t  lvl_d,
  input  logic               beep,
  output sound_pkg::sample_t sound_l,
  output sound_pkg::sample_t sound_r,
  output logic               sample_stb
);

  import sound_pkg::*;

  logic [$clog2(SAMPLE_DIV)-1:0] div_cnt;
  logic                          tick;
  logic                          s1_valid;
  mix_t                          mix_l;
  mix_t                          mix_r;
  mix_t                          beep_term;

  // Sample rate divider, fclk/64
  assign tick = (div_cnt == ($clog2(SAMPLE_DIV))'(SAMPLE_DIV - 1));

  always_ff @(posedge fclk) begin
    if (reset) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign beep_term = beep ? mix_t'(BEEP_W) : '0;

  // Stage 1: weighted sums, A+B left and C+D right
  always_ff @(posedge fclk) begin
    if (tick) begin
      mix_l <= mix_t'(lvl_a) * mix_t'(COVOX_W) + mix_t'(lvl_b) * mix_t'(COVOX_W) + beep_term;
      mix_r <= mix_t'(lvl_c) * mix_t'(COVOX_W) + mix_t'(lvl_d) * mix_t'(COVOX_W) + beep_term;
    end
  end

  always_ff @(posedge fclk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= tick;
    end
  end

  // Stage 2: widen to the output format
  always_ff @(posedge fclk) begin
    if (reset) begin
      sound_l    <= '0;
      sound_r    <= '0;
      sample_stb <= 1'b0;
    end else begin
      sample_stb <= s1_valid;
      if (s1_valid) begin
        sound_l <= sample_t'(mix_l) << (OUT_W - MIX_W);
        sound_r <= sample_t'(mix_r) << (OUT_W - MIX_W);
      end
    end
  end

  // Strobe period equals the divider period
  a_stb_period: assert property (
    @(posedge fclk) disable iff (reset)
    sample_stb |-> ##SAMPLE_DIV sample_stb
  );

endmodule

/* design/sound_top.sv */
`timescale 1ns/1ps

module sound_top (
  input  logic                         fclk,
  input  logic                         reset,
  input  logic [sound_pkg::ADDR_W-1:0] a,
  input  sound_pkg::level_t            d,
  input  logic                         iorq_n,
  input  logic                         wr_n,
  input  logic                         m1_n,
  input  logic                         dos,
  output sound_pkg::sample_t           sound_l,
  output sound_pkg::sample_t           sound_r,
  output logic                         sample_stb
);

  import sound_pkg::*;

  chan_mask_t chan_wr;
  logic       beep_wr;
  level_t     wr_data;
  level_t     lvl_a;
  level_t     lvl_b;
  level_t     lvl_c;
  level_t     lvl_d;
  logic       beep;

  snd_port_decode decode_i (
    .fclk    (fclk),
    .reset   (reset),
    .a       (a),
    .d       (d),
    .iorq_n  (iorq_n),
    .wr_n    (wr_n),
    .m1_n    (m1_n),
    .dos     (dos),
    .chan_wr (chan_wr),
    .beep_wr (beep_wr),
    .wr_data (wr_data)
  );

  level_regs regs_i (
    .fclk    (fclk),
    .reset   (reset),
    .chan_wr (chan_wr),
    .beep_wr (beep_wr),
    .wr_data (wr_data),
    .lvl_a   (lvl_a),
    .lvl_b   (lvl_b),
    .lvl_c   (lvl_c),
    .lvl_d   (lvl_d),
    .beep    (beep)
  );

  audio_mixer mixer_i (
    .fclk       (fclk),
    .reset      (reset),
    .lvl_a      (lvl_a),
    .lvl_b      (lvl_b),
    .lvl_c      (lvl_c),
    .lvl_d      (lvl_d),
    .beep       (beep),
    .sound_l    (sound_l),
    .sound_r    (sound_r),
    .sample_stb (sample_stb)
  );

endmodule

/* bench/tb_sound_top.sv */
`timescale 1ns/1ps

module tb_sound_top;

  import sound_pkg::*;

  localparam int STB_TIMEOUT = 200;
  localparam int N_RANDOM    = 40;

  logic              fclk;
  logic              reset;
  logic [ADDR_W-1:0] a;
  level_t            d;
  logic              iorq_n;
  logic              wr_n;
  logic              m1_n;
  logic              dos;
  sample_t           sound_l;
  sample_t           sound_r;
  logic              sample_stb;

  // Expected levels of channels A to D and the beeper bit
  int unsigned ref_lvl [4];
  logic        ref_beep;

  logic [7:0]  port_tab [7];
  int          stb_wait;
  int          pick;
  logic [7:0]  hi_byte;

  sound_top dut_i (
    .fclk       (fclk),
    .reset      (reset),
    .a          (a),
    .d          (d),
    .iorq_n     (iorq_n),
    .wr_n       (wr_n),
    .m1_n       (m1_n),
    .dos        (dos),
    .sound_l    (sound_l),
    .sound_r    (sound_r),
    .sample_stb (sample_stb)
  );

  always #4 fclk = ~fclk;

  // Inputs change and outputs are read 1 ns after the rising edge
  task automatic step();
    @(posedge fclk);
    #1;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic model_write(input logic [ADDR_W-1:0] addr, input level_t data,
                             input logic dos_v);
    if (!dos_v) begin
      case (addr[7:0])
        8'h0F: ref_lvl[0] = data;
        8'h1F: ref_lvl[1] = data;
        8'h4F: ref_lvl[2] = data;
        8'h5F: ref_lvl[3] = data;
        8'hFB: for (int i = 0; i < 4; i++) ref_lvl[i] = data;
        default: ;
      endcase
    end
    // Even ports all reach #FE
    if (!addr[0]) begin
      ref_beep = data[4];
    end
  endtask

  task automatic io_write(input logic [ADDR_W-1:0] addr, input level_t data,
                          input logic dos_v, input logic m1_v);
    a      = addr;
    d      = data;
    dos    = dos_v;
    m1_n   = m1_v;
    iorq_n = 1'b0;
    wr_n   = 1'b0;
    repeat (3) step();
    iorq_n = 1'b1;
    wr_n   = 1'b1;
    m1_n   = 1'b1;
    repeat (2) step();
    if (m1_v) begin
      model_write(addr, data, dos_v);
    end
  endtask

  task automatic wait_strobe(output int cycles);
    cycles = 0;
    step();
    cycles++;
    while (!sample_stb && cycles < STB_TIMEOUT) begin
      step();
      cycles++;
    end
    if (!sample_stb) begin
      abort_run("Timeout: sample_stb did not pulse within 200 cycles");
    end
  endtask

  task automatic check_sample(input string name);
    int unsigned exp_l;
    int unsigned exp_r;
    exp_l = 16 * (4 * ref_lvl[0] + 4 * ref_lvl[1] + (ref_beep ? 256 : 0));
    exp_r = 16 * (4 * ref_lvl[2] + 4 * ref_lvl[3] + (ref_beep ? 256 : 0));
    assert (32'(sound_l) == exp_l) else
      abort_run($sformatf("[FAIL] %s sound_l expected %0d actual %0d", name, exp_l, sound_l));
    assert (32'(sound_r) == exp_r) else
      abort_run($sformatf("[FAIL] %s sound_r expected %0d actual %0d", name, exp_r, sound_r));
  endtask

  // Second strobe after the last write always reflects it
  task automatic check_outputs(input string name);
    int cycles;
    wait_strobe(cycles);
    wait_strobe(cycles);
    check_sample(name);
  endtask

  initial begin
    fclk     = 1'b0;
    reset    = 1'b1;
    a        = '0;
    d        = '0;
    iorq_n   = 1'b1;
    wr_n     = 1'b1;
    m1_n     = 1'b1;
    dos      = 1'b0;
    ref_lvl  = '{0, 0, 0, 0};
    ref_beep = 1'b0;
    port_tab = '{8'h0F, 8'h1F, 8'h4F, 8'h5F, 8'hFB, 8'hFE, 8'h3D};
    void'($urandom(32'h0337_48b6));

    repeat (5) step();
    reset = 1'b0;

    // No strobe before the first divider tick
    wait_strobe(stb_wait);
    assert (stb_wait >= SAMPLE_DIV) else
      abort_run($sformatf("[FAIL] reset first strobe expected >= %0d cycles actual %0d",
                          SAMPLE_DIV, stb_wait));
    check_sample("reset");

    io_write(16'h000F, 8'h11, 1'b0, 1'b1);
    check_outputs("sd_a");
    io_write(16'h001F, 8'h22, 1'b0, 1'b1);
    check_outputs("sd_b");
    io_write(16'h004F, 8'h33, 1'b0, 1'b1);
    check_outputs("sd_c");
    io_write(16'h005F, 8'h44, 1'b0, 1'b1);
    check_outputs("sd_d");

    io_write(16'h12FB, 8'h5A, 1'b0, 1'b1);
    check_outputs("covox");

    io_write(16'h00FE, 8'h10, 1'b0, 1'b1);
    check_outputs("beep_on");
    io_write(16'h7FFE, 8'hEF, 1'b0, 1'b1);
    check_outputs("beep_off");
    io_write(16'h00FE, 8'h10, 1'b0, 1'b1);
    io_write(16'h0077, 8'h00, 1'b0, 1'b1);
    check_outputs("odd_port");

    io_write(16'h000F, 8'hAA, 1'b1, 1'b1);
    io_write(16'h00FB, 8'h55, 1'b1, 1'b1);
    io_write(16'h00FE, 8'h00, 1'b1, 1'b1);
    check_outputs("dos_gate");

    // M1 active marks an interrupt acknowledge, not a write
    io_write(16'h001F, 8'h99, 1'b0, 1'b0);
    io_write(16'h00FE, 8'h10, 1'b0, 1'b0);
    check_outputs("m1_gate");

    for (int n = 1; n <= N_RANDOM; n++) begin
      pick    = $urandom_range(0, 6);
      hi_byte = 8'($urandom);
      io_write({hi_byte, port_tab[pick]}, level_t'($urandom), 1'($urandom_range(0, 1)), 1'b1);
      if (n % 5 == 0) begin
        check_outputs($sformatf("random_%0d", n));
      end
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* sound_io.f */
design/sound_pkg.sv
design/snd_port_decode.sv
design/level_regs.sv
design/audio_mixer.sv
design/sound_top.sv
bench/tb_sound_top.sv

/* run.sh */
#!/bin/sh
# Build and run the sound I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
  --top-module tb_sound_top -f sound_io.f -o sim_sound \
  && ./obj_dir/sim_sound | tee /dev/stderr | grep "Result: PASSED" > /dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
